//--- renamePkg.sv
`default_nettype none

package renamePkg;

    // uops renamed and committed per cycle
    localparam int renameWidth = 2;

    // architectural and physical register file sizes
    localparam int numArchRegs = 16;
    localparam int numTags = 64;

    // out of reset arch reg r sits in tag r
    localparam int numResetTags = 16;
    localparam int resetFreeTags = numTags - numResetTags;

    typedef logic [3:0] archRegIdx;
    typedef logic [5:0] tagIdx;

    // tag word, top bit set means no register at all
    typedef logic [6:0] physTag;
    localparam int noTag = 6;
    localparam physTag nullTag = 7'h40;

    // uop register field, same idea with bit 4 as the none flag
    typedef logic [4:0] archWord;
    localparam int noReg = 4;

    // holds 0..64
    typedef logic [6:0] freeCount;

    // wrap a tag index as a present tag
    function automatic physTag toTag(tagIdx idx);
        return {1'b0, idx};
    endfunction

endpackage

`default_nettype wire

//--- tagRetireIf.sv
`timescale 1ns/1ps
`default_nettype none

interface tagRetireIf;

    // slot carries a commit with a destination
    logic retireValid [renamePkg::renameWidth];

    // tag pushed out of the committed map, gets freed
    renamePkg::physTag prevTag [renamePkg::renameWidth];

    // tag the committed map now points at
    renamePkg::physTag newTag [renamePkg::renameWidth];

    // drop all speculative state at the next edge
    logic mispredict;

    // rename table side produces everything
    modport aliasTable (
        output retireValid,
        output prevTag,
        output newTag,
        output mispredict
    );

    // tag buffer only samples at the clock edge
    modport buffer (
        input retireValid,
        input prevTag,
        input newTag,
        input mispredict
    );

endinterface

`default_nettype wire

//--- tagBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module tagBuffer (
    input wire clk,
    input wire rst,
    tagRetireIf.buffer retire,
    input wire allocTake [renamePkg::renameWidth],
    output renamePkg::physTag allocTag [renamePkg::renameWidth],
    output logic allocReady,
    output renamePkg::freeCount freeTags
);

    // per tag state, committed implies used
    logic [renamePkg::numTags-1:0] used;
    logic [renamePkg::numTags-1:0] committed;

    // tags not held by the committed map
    renamePkg::freeCount freeCom;

    // next state, built up slot by slot
    logic [renamePkg::numTags-1:0] usedNext;
    logic [renamePkg::numTags-1:0] committedNext;
    renamePkg::freeCount freeNext;
    renamePkg::freeCount freeComNext;

    // the two highest free tags
    renamePkg::tagIdx pick [renamePkg::renameWidth];
    logic pickOk [renamePkg::renameWidth];

    // priority pick, scanning upward so the last hits win
    always_comb begin
        for (int s = 0; s < renamePkg::renameWidth; s++) begin
            pick[s] = '0;
            pickOk[s] = 1'b0;
        end
        for (int j = 0; j < renamePkg::numTags; j++) begin
            if (!used[j]) begin
                // previous best slides down to slot 1
                pick[1] = pick[0];
                pickOk[1] = pickOk[0];
                pick[0] = renamePkg::tagIdx'(j);
                pickOk[0] = 1'b1;
            end
        end
    end

    always_comb begin
        for (int s = 0; s < renamePkg::renameWidth; s++) begin
            // nullTag when the list runs dry
            allocTag[s] = pickOk[s] ? renamePkg::toTag(pick[s]) : renamePkg::nullTag;
        end
    end

    // a full group needs one tag per slot
    assign allocReady = freeTags >= renamePkg::freeCount'(renamePkg::renameWidth);

    always_comb begin
        usedNext = used;
        committedNext = committed;
        freeNext = freeTags;
        freeComNext = freeCom;

        // allocation, never in a mispredict cycle
        if (!retire.mispredict) begin
            for (int s = 0; s < renamePkg::renameWidth; s++) begin
                if (allocTake[s] && !allocTag[s][renamePkg::noTag]) begin
                    usedNext[allocTag[s][5:0]] = 1'b1;
                    freeNext = freeNext - 7'd1;
                end
            end
        end

        // commits are honored even alongside a mispredict
        for (int s = 0; s < renamePkg::renameWidth; s++) begin
            if (retire.retireValid[s]) begin
                // old committed tag goes back to the pool
                if (usedNext[retire.prevTag[s][5:0]]) begin
                    freeNext = freeNext + 7'd1;
                end
                if (committedNext[retire.prevTag[s][5:0]]) begin
                    freeComNext = freeComNext + 7'd1;
                end
                usedNext[retire.prevTag[s][5:0]] = 1'b0;
                committedNext[retire.prevTag[s][5:0]] = 1'b0;

                // new tag was allocated at rename, now pinned
                if (!committedNext[retire.newTag[s][5:0]]) begin
                    freeComNext = freeComNext - 7'd1;
                end
                committedNext[retire.newTag[s][5:0]] = 1'b1;
            end
        end

        // everything speculative is released
        if (retire.mispredict) begin
            usedNext = committedNext;
            freeNext = freeComNext;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int j = 0; j < renamePkg::numTags; j++) begin
                // low tags back the identity map
                used[j] <= (j < renamePkg::numResetTags);
                committed[j] <= (j < renamePkg::numResetTags);
            end
            freeTags <= renamePkg::freeCount'(renamePkg::resetFreeTags);
            freeCom <= renamePkg::freeCount'(renamePkg::resetFreeTags);
        end else begin
            used <= usedNext;
            committed <= committedNext;
            freeTags <= freeNext;
            freeCom <= freeComNext;
        end
    end

endmodule

`default_nettype wire

//--- renameTable.sv
`timescale 1ns/1ps
`default_nettype none

module renameTable (
    input wire clk,
    input wire rst,
    input wire renameValid [renamePkg::renameWidth],
    input wire renamePkg::archWord srcA [renamePkg::renameWidth],
    input wire renamePkg::archWord srcB [renamePkg::renameWidth],
    input wire renamePkg::archWord dst [renamePkg::renameWidth],
    input wire commitValid [renamePkg::renameWidth],
    input wire renamePkg::archWord commitArch [renamePkg::renameWidth],
    input wire renamePkg::physTag commitTag [renamePkg::renameWidth],
    input wire mispredict,
    input wire renamePkg::physTag allocTag [renamePkg::renameWidth],
    input wire allocReady,
    output logic allocTake [renamePkg::renameWidth],
    output renamePkg::physTag srcTagA [renamePkg::renameWidth],
    output renamePkg::physTag srcTagB [renamePkg::renameWidth],
    output renamePkg::physTag dstTag [renamePkg::renameWidth],
    output logic renameReady,
    tagRetireIf.aliasTable retire
);

    // speculative map, written at rename
    renamePkg::tagIdx specMap [renamePkg::numArchRegs];
    // committed map, written at commit
    renamePkg::tagIdx comMap [renamePkg::numArchRegs];
    // committed map after this cycle's commits
    renamePkg::tagIdx comNext [renamePkg::numArchRegs];

    // slot writes a destination this cycle
    logic take [renamePkg::renameWidth];

    // plain lookup in the speculative map
    function automatic renamePkg::physTag mapRead(renamePkg::archWord r);
        if (r[renamePkg::noReg]) begin
            return renamePkg::nullTag;
        end
        return renamePkg::toTag(specMap[r[3:0]]);
    endfunction

    // slot 1 source matches slot 0's destination
    function automatic logic hitsDst0(renamePkg::archWord r);
        return take[0] && !r[renamePkg::noReg] && (r[3:0] == dst[0][3:0]);
    endfunction

    always_comb begin
        // rename inputs are dead during a mispredict
        for (int s = 0; s < renamePkg::renameWidth; s++) begin
            take[s] = renameValid[s] && !mispredict && !dst[s][renamePkg::noReg];
        end

        // buffer hands out from the top, so a lone taker uses slot 0's tag
        allocTake[0] = take[0] || take[1];
        allocTake[1] = take[0] && take[1];

        dstTag[0] = take[0] ? allocTag[0] : renamePkg::nullTag;
        if (take[1]) begin
            dstTag[1] = take[0] ? allocTag[1] : allocTag[0];
        end else begin
            dstTag[1] = renamePkg::nullTag;
        end
    end

    always_comb begin
        srcTagA[0] = mapRead(srcA[0]);
        srcTagB[0] = mapRead(srcB[0]);
        // intra-group dependency, forward slot 0's fresh tag
        srcTagA[1] = hitsDst0(srcA[1]) ? dstTag[0] : mapRead(srcA[1]);
        srcTagB[1] = hitsDst0(srcB[1]) ? dstTag[0] : mapRead(srcB[1]);
    end

    assign renameReady = allocReady;

    // commit path, slot 1 sees slot 0's update
    always_comb begin
        renamePkg::archRegIdx ca;
        comNext = comMap;
        for (int s = 0; s < renamePkg::renameWidth; s++) begin
            ca = commitArch[s][3:0];
            retire.retireValid[s] = commitValid[s] && !commitArch[s][renamePkg::noReg]
                && !commitTag[s][renamePkg::noTag];
            // read before write gives the displaced tag
            retire.prevTag[s] = renamePkg::toTag(comNext[ca]);
            retire.newTag[s] = commitTag[s];
            if (retire.retireValid[s]) begin
                comNext[ca] = commitTag[s][5:0];
            end
        end
        retire.mispredict = mispredict;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // identity in both maps
            for (int r = 0; r < renamePkg::numArchRegs; r++) begin
                specMap[r] <= renamePkg::tagIdx'(r);
                comMap[r] <= renamePkg::tagIdx'(r);
            end
        end else begin
            comMap <= comNext;
            if (mispredict) begin
                // recover, including commits from this very cycle
                specMap <= comNext;
            end else begin
                // slot 1 lands last and wins on a shared dst
                for (int s = 0; s < renamePkg::renameWidth; s++) begin
                    if (take[s]) begin
                        specMap[dst[s][3:0]] <= dstTag[s][5:0];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- renameUnit.sv
`timescale 1ns/1ps
`default_nettype none

module renameUnit (
    input wire clk,
    input wire rst,

    // rename group from decode
    input wire renameValid [renamePkg::renameWidth],
    input wire renamePkg::archWord srcA [renamePkg::renameWidth],
    input wire renamePkg::archWord srcB [renamePkg::renameWidth],
    input wire renamePkg::archWord dst [renamePkg::renameWidth],

    // commit stream from the ROB
    input wire commitValid [renamePkg::renameWidth],
    input wire renamePkg::archWord commitArch [renamePkg::renameWidth],
    input wire renamePkg::physTag commitTag [renamePkg::renameWidth],
    input wire mispredict,

    // renamed operands, same cycle
    output renamePkg::physTag srcTagA [renamePkg::renameWidth],
    output renamePkg::physTag srcTagB [renamePkg::renameWidth],
    output renamePkg::physTag dstTag [renamePkg::renameWidth],
    output logic renameReady,
    output renamePkg::freeCount freeTags
);

    // free list to table
    renamePkg::physTag allocTag [renamePkg::renameWidth];
    logic allocReady;
    // table back to free list
    logic allocTake [renamePkg::renameWidth];

    // commit frees and flush
    tagRetireIf retireBus ();

    renameTable uTable (
        .clk(clk),
        .rst(rst),
        .renameValid(renameValid),
        .srcA(srcA),
        .srcB(srcB),
        .dst(dst),
        .commitValid(commitValid),
        .commitArch(commitArch),
        .commitTag(commitTag),
        .mispredict(mispredict),
        .allocTag(allocTag),
        .allocReady(allocReady),
        .allocTake(allocTake),
        .srcTagA(srcTagA),
        .srcTagB(srcTagB),
        .dstTag(dstTag),
        .renameReady(renameReady),
        .retire(retireBus.aliasTable)
    );

    tagBuffer uTags (
        .clk(clk),
        .rst(rst),
        .retire(retireBus.buffer),
        .allocTake(allocTake),
        .allocTag(allocTag),
        .allocReady(allocReady),
        .freeTags(freeTags)
    );

endmodule

`default_nettype wire

//--- tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic rst
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // held over the first four rising edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- renameUnit_props.sv
`timescale 1ns/1ps
`default_nettype none

module renameUnit_props (
    input wire clk,
    input wire rst,
    input wire renameValid [renamePkg::renameWidth],
    input wire renameReady,
    input wire mispredict,
    input wire allocTake [renamePkg::renameWidth],
    input wire renamePkg::physTag allocTag [renamePkg::renameWidth],
    input wire renamePkg::physTag dstTag [renamePkg::renameWidth]
);

    // a group only while two tags are on hand
    groupNeedsReady: assert property (@(posedge clk) disable iff (rst)
        (renameValid[0] || renameValid[1]) |-> renameReady)
        else $error("rename group presented while renameReady was low");

    // a consumed tag is a real register
    takeHasTag: assert property (@(posedge clk) disable iff (rst)
        allocTake[0] |-> !allocTag[0][renamePkg::noTag])
        else $error("tag taken while the free list was empty");

    // two writers never share one tag
    distinctTags: assert property (@(posedge clk) disable iff (rst)
        allocTake[1] |-> (dstTag[0] != dstTag[1]))
        else $error("both slots received the same tag");

    // only committed tags survive a flush, so a full group fits again
    flushRestoresReady: assert property (@(posedge clk) disable iff (rst)
        mispredict |=> renameReady)
        else $error("renameReady still low the cycle after a mispredict");

endmodule

bind renameTable renameUnit_props uProps (
    .clk(clk),
    .rst(rst),
    .renameValid(renameValid),
    .renameReady(renameReady),
    .mispredict(mispredict),
    .allocTake(allocTake),
    .allocTag(allocTag),
    .dstTag(dstTag)
);

`default_nettype wire

//--- renameUnit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module renameUnit_tb;

    logic clk;
    logic rst;
    logic renameValid [renamePkg::renameWidth];
    renamePkg::archWord srcA [renamePkg::renameWidth];
    renamePkg::archWord srcB [renamePkg::renameWidth];
    renamePkg::archWord dst [renamePkg::renameWidth];
    logic commitValid [renamePkg::renameWidth];
    renamePkg::archWord commitArch [renamePkg::renameWidth];
    renamePkg::physTag commitTag [renamePkg::renameWidth];
    logic mispredict;
    renamePkg::physTag srcTagA [renamePkg::renameWidth];
    renamePkg::physTag srcTagB [renamePkg::renameWidth];
    renamePkg::physTag dstTag [renamePkg::renameWidth];
    logic renameReady;
    renamePkg::freeCount freeTags;

    // model maps where register 16 is the none word and reads as tag 64
    int specRef [17];
    int comRef [17];
    bit usedRef [renamePkg::numTags];
    bit pinnedRef [renamePkg::numTags];
    // ROB stand-in holding the oldest rename first
    int pendArch [$];
    int pendTag [$];

    tbClock uClock (.clk(clk), .rst(rst));
    renameUnit u_dut (.*);

    // highest free tag other than skip or 64 when none is left
    function automatic int highestFree(int skip);
        for (int j = renamePkg::numTags - 1; j >= 0; j--) begin
            if (!usedRef[j] && j != skip) begin
                return j;
            end
        end
        return 64;
    endfunction

    function automatic int freeRef();
        int n = 0;
        foreach (usedRef[j]) begin
            n += int'(!usedRef[j]);
        end
        return n;
    endfunction

    task automatic checkValue(input string what, input int got, input int exp);
        assert (got == exp) else begin
            $display("ERROR at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic clearInputs();
        renameValid = '{default: 1'b0};
        srcA = '{default: 5'h10};
        srcB = '{default: 5'h10};
        dst = '{default: 5'h10};
        commitValid = '{default: 1'b0};
        commitArch = '{default: 5'h10};
        commitTag = '{default: 7'h40};
        mispredict = 1'b0;
    endtask

    // let the edge land and then compare the counters
    task automatic endCycle();
        @(posedge clk);
        #1;
        clearInputs();
        checkValue("freeTags", int'(freeTags), freeRef());
        checkValue("renameReady", int'(renameReady), int'(freeRef() >= 2));
    endtask

    // both slots valid and register 16 means none
    task automatic renameGroup(input int d0, input int a0, input int b0,
                               input int d1, input int a1, input int b1);
        int t0;
        int t1;
        // tags come off the top and a lone slot 1 writer gets slot 0's tag
        t0 = (d0 < 16) ? highestFree(-1) : 64;
        t1 = (d1 >= 16) ? 64 : ((d0 < 16) ? highestFree(t0) : highestFree(-1));
        renameValid = '{1'b1, 1'b1};
        srcA = '{5'(a0), 5'(a1)};
        srcB = '{5'(b0), 5'(b1)};
        dst = '{5'(d0), 5'(d1)};
        #10;
        checkValue("slot 0 srcTagA", int'(srcTagA[0]), specRef[a0]);
        checkValue("slot 0 srcTagB", int'(srcTagB[0]), specRef[b0]);
        // slot 1 reads slot 0's fresh tag
        checkValue("slot 1 srcTagA", int'(srcTagA[1]),
                   (d0 < 16 && a1 == d0) ? t0 : specRef[a1]);
        checkValue("slot 1 srcTagB", int'(srcTagB[1]),
                   (d0 < 16 && b1 == d0) ? t0 : specRef[b1]);
        checkValue("slot 0 dstTag", int'(dstTag[0]), t0);
        checkValue("slot 1 dstTag", int'(dstTag[1]), t1);
        if (d0 < 16) begin
            specRef[d0] = t0;
            usedRef[t0] = 1'b1;
            pendArch.push_back(d0);
            pendTag.push_back(t0);
        end
        // slot 1 lands last on a shared dst
        if (d1 < 16) begin
            specRef[d1] = t1;
            usedRef[t1] = 1'b1;
            pendArch.push_back(d1);
            pendTag.push_back(t1);
        end
        endCycle();
    endtask

    // oldest renames retire in order and the displaced committed tag is freed
    task automatic loadCommits(input int n);
        int a;
        for (int s = 0; s < n; s++) begin
            a = pendArch.pop_front();
            commitValid[s] = 1'b1;
            commitArch[s] = 5'(a);
            commitTag[s] = 7'(pendTag[0]);
            usedRef[comRef[a]] = 1'b0;
            pinnedRef[comRef[a]] = 1'b0;
            comRef[a] = pendTag.pop_front();
            pinnedRef[comRef[a]] = 1'b1;
        end
    endtask

    // every register as a source with nothing written
    task automatic lookupAll();
        for (int g = 0; g < 16; g += 4) begin
            renameGroup(16, g, g + 1, 16, g + 2, g + 3);
        end
    endtask

    task automatic afterReset();
        checkValue("freeTags after reset", int'(freeTags), 48);
        checkValue("renameReady after reset", int'(renameReady), 1);
        lookupAll();
    endtask

    task automatic allocOrder();
        // 63 and 62 first
        renameGroup($urandom_range(15, 0), 16, 16, $urandom_range(15, 0), 16, 16);
        checkValue("freeTags after two dsts", int'(freeTags), 46);
        renameGroup(16, $urandom_range(15, 0), 16, $urandom_range(15, 0), 16, 16);
        renameGroup($urandom_range(15, 0), 16, 16, $urandom_range(15, 0), 16, 16);
        checkValue("freeTags after five dsts", int'(freeTags), 43);
    endtask

    task automatic slotBypass();
        int r;
        r = $urandom_range(15, 0);
        // slot 0 writes r and slot 1 reads it in both operands
        renameGroup(r, 16, 16, (r + 1) % 16, r, r);
        renameGroup(16, r, (r + 1) % 16, 16, (r + 1) % 16, r);
    endtask

    task automatic commitFree();
        int r;
        while (pendArch.size() > 0) begin
            loadCommits(pendArch.size() > 1 ? 2 : 1);
            endCycle();
        end
        r = $urandom_range(15, 0);
        // committing both displaces slot 0's top tag
        renameGroup(r, 16, 16, r, 16, 16);
        loadCommits(2);
        endCycle();
        // that tag is handed out first again
        renameGroup(r, 16, 16, 16, 16, 16);
    endtask

    task automatic flushRecovery();
        renameGroup($urandom_range(15, 0), 16, 16, $urandom_range(15, 0), 16, 16);
        renameGroup($urandom_range(15, 0), 3, 16, $urandom_range(15, 0), 16, 7);
        loadCommits(1);
        endCycle();
        // one commit still lands in the flush cycle
        loadCommits(1);
        mispredict = 1'b1;
        // a group in the flush cycle leaves no trace
        renameValid = '{1'b1, 1'b1};
        dst = '{5'($urandom_range(15, 0)), 5'($urandom_range(15, 0))};
        specRef = comRef;
        usedRef = pinnedRef;
        pendArch.delete();
        pendTag.delete();
        endCycle();
        checkValue("freeTags after flush", int'(freeTags), 48);
        lookupAll();
    endtask

    task automatic tagExhaustion();
        while (freeRef() >= 2) begin
            renameGroup($urandom_range(15, 0), 16, 16, $urandom_range(15, 0), 16, 16);
        end
        checkValue("renameReady with no spare tags", int'(renameReady), 0);
        loadCommits(2);
        endCycle();
        checkValue("renameReady after commits", int'(renameReady), 1);
    endtask

    initial begin
        void'($urandom(4014));
        clearInputs();
        // identity maps with low tags held and committed
        for (int r = 0; r < 17; r++) begin
            specRef[r] = (r < 16) ? r : 64;
            comRef[r] = specRef[r];
        end
        foreach (usedRef[j]) begin
            usedRef[j] = j < renamePkg::numResetTags;
            pinnedRef[j] = usedRef[j];
        end
        @(negedge rst);
        afterReset();
        allocOrder();
        slotBypass();
        commitFree();
        flushRecovery();
        tagExhaustion();
        $display("Verification passed");
        $finish;
    end

    // reset plus about 49 test cycles and a margin
    initial begin
        #((4 + 49 + 50) * 100);
        $display("timeout, the tests did not finish in time");
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- build.f
renamePkg.sv
tagRetireIf.sv
tagBuffer.sv
renameTable.sv
renameUnit.sv
tbClock.sv
renameUnit_props.sv
renameUnit_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module renameUnit_tb -f build.f \
    && ./obj_dir/VrenameUnit_tb \
    || exit 1
